/* Makefile */
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wno-fatal
TOP        ?= tb_vlane_driver
RTL_TOP    ?= vlane_driver_top
FILELIST   ?= compile.f
OBJ_DIR    ?= obj_dir
PASS_MSG   := Test passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* compile.f */
+incdir+include
hw/vlane_pkg.sv
hw/driver_apb_regs.sv
hw/driver_vlane_interconnect.sv
hw/lane_issue_gate.sv
hw/vlane_driver_top.sv
verif/tb_vlane_driver.sv

/* hw/driver_apb_regs.sv */
`timescale 1ns/1ps
`include "vlane_settings.svh"

module driver_apb_regs (
    input  logic clk_i,
    input  logic rst_i,

    // APB slave
    input  logic apb_psel_i,
    input  logic apb_penable_i,
    input  logic apb_pwrite_i,
    input  logic [`VLANE_APB_AW-1:0] apb_paddr_i,
    input  logic [31:0] apb_pwdata_i,
    output logic [31:0] apb_prdata_o,
    output logic apb_pready_o,
    output logic apb_pslverr_o,

    // Counter readback
    input  logic [`VLANE_NUM-1:0][`VLANE_CNT_W-1:0] lane_cnt_i,

    // Command towards the interconnect
    output logic issue_stb_o,
    output logic [`VLANE_NUM-1:0] lane_en_o,
    output logic [`VLANE_R_PORTS-1:0][`VLANE_RSEL_W-1:0] ralloc_o,
    output logic [`VLANE_W_PORTS-1:0][`VLANE_ADDR_W-1:0] port_raddr_o,
    output logic [`VLANE_W_PORTS-1:0] port_ren_o,
    output logic [`VLANE_W_PORTS-2:0][`VLANE_BWEN_W-1:0] port_bwen_o,
    output vlane_pkg::alu_op_e [`VLANE_W_PORTS-1:0] port_op_o,
    output logic [`VLANE_W_PORTS-1:0][`VLANE_XDATA_W-1:0] port_xdata_o,
    output logic [`VLANE_W_PORTS-2:0][`VLANE_ADDR_W-1:0] port_waddr_part_o,
    output logic [`VLANE_NUM-1:0][`VLANE_ADDR_W-1:0] lane_waddr_cmp_o,
    output logic [`VLANE_NUM-1:0][`VLANE_BWEN_W-1:0] lane_bwen_cmp_o
);

    import vlane_pkg::*;

    apb_phase_e apb_phase;
    reg_ofs_e ofs_sel;
    logic [1:0] ofs_idx;
    logic ofs_bad;
    logic apb_wr;
    logic [31:0] rd_data;

    // Register bank
    logic issue_q;
    logic [`VLANE_NUM-1:0] lane_en_q;
    logic [`VLANE_R_PORTS-1:0][`VLANE_RSEL_W-1:0] ralloc_q;
    logic [`VLANE_W_PORTS-1:0][26:0] port_cmd_q;
    logic [`VLANE_W_PORTS-1:0][`VLANE_XDATA_W-1:0] port_xdata_q;
    logic [`VLANE_NUM-1:0][`VLANE_ADDR_W+`VLANE_BWEN_W-1:0] lane_wr_q;

    ////////////////////////////////////////
    // APB decode

    always_comb begin
        if (!apb_psel_i) begin
            apb_phase = APB_IDLE;
        end else if (!apb_penable_i) begin
            apb_phase = APB_SETUP;
        end else begin
            apb_phase = APB_ACCESS;
        end
    end

    // Low group holds single registers, the others are indexed by bits 3..2
    assign ofs_idx = apb_paddr_i[3:2];
    assign ofs_sel = (apb_paddr_i[7:4] == 4'h0) ? reg_ofs_e'(apb_paddr_i)
                                                : reg_ofs_e'({apb_paddr_i[7:4], 4'h0});

    always_comb begin
        rd_data = '0;
        ofs_bad = (apb_paddr_i[1:0] != 2'b00);
        case (ofs_sel)
            REG_CTRL:       rd_data[8 +: `VLANE_NUM] = lane_en_q;
            REG_RALLOC:     rd_data[`VLANE_R_PORTS*`VLANE_RSEL_W-1:0] = ralloc_q;
            REG_PORT_CMD:   rd_data[26:0] = port_cmd_q[ofs_idx];
            REG_PORT_XDATA: rd_data = port_xdata_q[ofs_idx];
            REG_LANE_WR:    rd_data[`VLANE_ADDR_W+`VLANE_BWEN_W-1:0] = lane_wr_q[ofs_idx];
            REG_LANE_CNT:   rd_data[`VLANE_CNT_W-1:0] = lane_cnt_i[ofs_idx];
            default:        ofs_bad = 1'b1;
        endcase
    end

    assign apb_wr = (apb_phase == APB_ACCESS) && apb_pwrite_i && !ofs_bad;

    assign apb_prdata_o  = rd_data;
    assign apb_pready_o  = 1'b1;
    // Counters are read only
    assign apb_pslverr_o = (apb_phase == APB_ACCESS) &&
                           (ofs_bad || (apb_pwrite_i && ofs_sel == REG_LANE_CNT));

    ////////////////////////////////////////
    // Register updates

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            issue_q      <= 1'b0;
            lane_en_q    <= '1;
            port_cmd_q   <= '0;
            port_xdata_q <= '0;
            lane_wr_q    <= '0;
            for (int k = 0; k < `VLANE_R_PORTS; k++) begin
                ralloc_q[k] <= `VLANE_RSEL_W'(k % `VLANE_W_PORTS);
            end
        end else begin
            // Issue bit is a pulse, never stored
            issue_q <= apb_wr && (ofs_sel == REG_CTRL) && apb_pwdata_i[0];
            if (apb_wr) begin
                case (ofs_sel)
                    REG_CTRL:       lane_en_q <= apb_pwdata_i[8 +: `VLANE_NUM];
                    REG_RALLOC:     ralloc_q <= apb_pwdata_i[`VLANE_R_PORTS*`VLANE_RSEL_W-1:0];
                    REG_PORT_CMD:   port_cmd_q[ofs_idx] <= apb_pwdata_i[26:0];
                    REG_PORT_XDATA: port_xdata_q[ofs_idx] <= apb_pwdata_i;
                    REG_LANE_WR: begin
                        lane_wr_q[ofs_idx] <= apb_pwdata_i[`VLANE_ADDR_W+`VLANE_BWEN_W-1:0];
                    end
                    default: ;
                endcase
            end
        end
    end

    ////////////////////////////////////////
    // Field extraction

    always_comb begin
        for (int p = 0; p < `VLANE_W_PORTS; p++) begin
            port_raddr_o[p] = port_cmd_q[p][`VLANE_ADDR_W-1:0];
            port_ren_o[p]   = port_cmd_q[p][9];
            port_op_o[p]    = alu_op_e'(port_cmd_q[p][17:14]);
        end
        // Port 0 takes bwen and waddr from the lane registers instead
        for (int p = 1; p < `VLANE_W_PORTS; p++) begin
            port_bwen_o[p-1]       = port_cmd_q[p][13:10];
            port_waddr_part_o[p-1] = port_cmd_q[p][26:18];
        end
        for (int l = 0; l < `VLANE_NUM; l++) begin
            lane_waddr_cmp_o[l] = lane_wr_q[l][`VLANE_ADDR_W-1:0];
            lane_bwen_cmp_o[l]  = lane_wr_q[l][`VLANE_ADDR_W +: `VLANE_BWEN_W];
        end
    end

    assign port_xdata_o = port_xdata_q;
    assign ralloc_o     = ralloc_q;
    assign lane_en_o    = lane_en_q;
    assign issue_stb_o  = issue_q;

endmodule

/* hw/driver_vlane_interconnect.sv */
`timescale 1ns/1ps
`include "vlane_settings.svh"

module driver_vlane_interconnect (
    input  logic clk_i,
    input  logic rst_i,
    input  logic issue_stb_i,

    // Per write port command fields
    input  logic [`VLANE_W_PORTS-1:0][`VLANE_ADDR_W-1:0] port_raddr_i,
    input  logic [`VLANE_W_PORTS-1:0] port_ren_i,
    input  logic [`VLANE_W_PORTS-2:0][`VLANE_BWEN_W-1:0] port_bwen_i,
    input  vlane_pkg::alu_op_e [`VLANE_W_PORTS-1:0] port_op_i,
    input  logic [`VLANE_W_PORTS-1:0][`VLANE_XDATA_W-1:0] port_xdata_i,
    input  logic [`VLANE_W_PORTS-2:0][`VLANE_ADDR_W-1:0] port_waddr_part_i,

    // Complete write port, one per lane
    input  logic [`VLANE_NUM-1:0][`VLANE_ADDR_W-1:0] lane_waddr_cmp_i,
    input  logic [`VLANE_NUM-1:0][`VLANE_BWEN_W-1:0] lane_bwen_cmp_i,

    // Read port allocation table
    input  logic [`VLANE_R_PORTS-1:0][`VLANE_RSEL_W-1:0] ralloc_i,

    // Fanned out to the lanes
    output logic cmd_valid_o,
    output logic [`VLANE_NUM-1:0][`VLANE_W_PORTS-1:0][`VLANE_ADDR_W-1:0] vrf_waddr_o,
    output logic [`VLANE_NUM-1:0][`VLANE_W_PORTS-1:0][`VLANE_BWEN_W-1:0] vrf_bwen_o,
    output vlane_pkg::alu_op_e [`VLANE_NUM-1:0][`VLANE_W_PORTS-1:0] alu_op_o,
    output logic [`VLANE_NUM-1:0][`VLANE_W_PORTS-1:0][`VLANE_XDATA_W-1:0] alu_x_data_o,
    output logic [`VLANE_NUM-1:0][`VLANE_R_PORTS-1:0] vrf_ren_o,
    output logic [`VLANE_NUM-1:0][`VLANE_R_PORTS-1:0][`VLANE_ADDR_W-1:0] vrf_raddr_o
);

    import vlane_pkg::*;

    // Input register layer, loaded on issue
    logic cmd_valid_q;
    logic [`VLANE_W_PORTS-1:0][`VLANE_ADDR_W-1:0] raddr_q;
    logic [`VLANE_W_PORTS-1:0] ren_q;
    logic [`VLANE_W_PORTS-2:0][`VLANE_BWEN_W-1:0] bwen_part_q;
    alu_op_e [`VLANE_W_PORTS-1:0] op_q;
    logic [`VLANE_W_PORTS-1:0][`VLANE_XDATA_W-1:0] xdata_q;
    logic [`VLANE_W_PORTS-2:0][`VLANE_ADDR_W-1:0] waddr_part_q;
    logic [`VLANE_NUM-1:0][`VLANE_ADDR_W-1:0] waddr_cmp_q;
    logic [`VLANE_NUM-1:0][`VLANE_BWEN_W-1:0] bwen_cmp_q;
    logic [`VLANE_R_PORTS-1:0][`VLANE_RSEL_W-1:0] ralloc_q;

    // Write port picked by each read port
    logic [`VLANE_R_PORTS-1:0][`VLANE_WSEL_W-1:0] rsel;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            cmd_valid_q  <= 1'b0;
            raddr_q      <= '0;
            ren_q        <= '0;
            bwen_part_q  <= '0;
            op_q         <= '0;
            xdata_q      <= '0;
            waddr_part_q <= '0;
            waddr_cmp_q  <= '0;
            bwen_cmp_q   <= '0;
            ralloc_q     <= '0;
        end else begin
            cmd_valid_q <= issue_stb_i;
            // Allocation is captured too, so a later RALLOC write waits for the next issue
            if (issue_stb_i) begin
                raddr_q      <= port_raddr_i;
                ren_q        <= port_ren_i;
                bwen_part_q  <= port_bwen_i;
                op_q         <= port_op_i;
                xdata_q      <= port_xdata_i;
                waddr_part_q <= port_waddr_part_i;
                waddr_cmp_q  <= lane_waddr_cmp_i;
                bwen_cmp_q   <= lane_bwen_cmp_i;
                ralloc_q     <= ralloc_i;
            end
        end
    end

    assign cmd_valid_o = cmd_valid_q;

    ////////////////////////////////////////
    // Lane fan-out

    // Entries beyond the port count wrap onto the low bits
    always_comb begin
        for (int k = 0; k < `VLANE_R_PORTS; k++) begin
            rsel[k] = ralloc_q[k][`VLANE_WSEL_W-1:0];
        end
    end

    for (genvar i = 0; i < `VLANE_NUM; i++) begin : g_lane
        for (genvar j = 0; j < `VLANE_W_PORTS; j++) begin : g_wport
            assign alu_op_o[i][j]     = op_q[j];
            assign alu_x_data_o[i][j] = xdata_q[j];
            if (j == 0) begin : g_cmp
                // Complete port, own address and bwen per lane
                assign vrf_waddr_o[i][j] = waddr_cmp_q[i];
                assign vrf_bwen_o[i][j]  = bwen_cmp_q[i];
            end else begin : g_part
                assign vrf_waddr_o[i][j] = waddr_part_q[j-1];
                assign vrf_bwen_o[i][j]  = bwen_part_q[j-1];
            end
        end

        for (genvar k = 0; k < `VLANE_R_PORTS; k++) begin : g_rport
            assign vrf_ren_o[i][k]   = ren_q[rsel[k]];
            assign vrf_raddr_o[i][k] = raddr_q[rsel[k]];
        end
    end

endmodule

/* hw/lane_issue_gate.sv */
`timescale 1ns/1ps
`include "vlane_settings.svh"

module lane_issue_gate (
    input  logic clk_i,
    input  logic rst_i,

    // Registered command valid from the interconnect
    input  logic cmd_valid_i,
    // Enable mask from CTRL
    input  logic [`VLANE_NUM-1:0] lane_en_i,

    output logic [`VLANE_NUM-1:0] lane_valid_o,
    output logic [`VLANE_NUM-1:0][`VLANE_CNT_W-1:0] lane_cnt_o
);

    logic [`VLANE_NUM-1:0][`VLANE_CNT_W-1:0] cnt_q;
    logic [`VLANE_NUM-1:0] cnt_full;

    ////////////////////////////////////////
    // Lane valid

    // Lanes always accept, so the mask is the only qualifier
    assign lane_valid_o = {`VLANE_NUM{cmd_valid_i}} & lane_en_i;

    ////////////////////////////////////////
    // Issue counters

    always_comb begin
        for (int l = 0; l < `VLANE_NUM; l++) begin
            cnt_full[l] = &cnt_q[l];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            cnt_q <= '0;
        end else begin
            for (int l = 0; l < `VLANE_NUM; l++) begin
                // Hold at all ones once saturated
                if (lane_valid_o[l] && !cnt_full[l]) begin
                    cnt_q[l] <= cnt_q[l] + 1'b1;
                end
            end
        end
    end

    assign lane_cnt_o = cnt_q;

endmodule

/* hw/vlane_driver_top.sv */
`timescale 1ns/1ps
`include "vlane_settings.svh"

module vlane_driver_top (
    input  logic clk_i,
    input  logic rst_i,

    // APB slave
    input  logic apb_psel_i,
    input  logic apb_penable_i,
    input  logic apb_pwrite_i,
    input  logic [`VLANE_APB_AW-1:0] apb_paddr_i,
    input  logic [31:0] apb_pwdata_i,
    output logic [31:0] apb_prdata_o,
    output logic apb_pready_o,
    output logic apb_pslverr_o,

    // Lane command ports
    output logic [`VLANE_NUM-1:0] lane_valid_o,
    output logic [`VLANE_NUM-1:0][`VLANE_W_PORTS-1:0][`VLANE_ADDR_W-1:0] lane_vrf_waddr_o,
    output logic [`VLANE_NUM-1:0][`VLANE_W_PORTS-1:0][`VLANE_BWEN_W-1:0] lane_vrf_bwen_o,
    output vlane_pkg::alu_op_e [`VLANE_NUM-1:0][`VLANE_W_PORTS-1:0] lane_alu_op_o,
    output logic [`VLANE_NUM-1:0][`VLANE_W_PORTS-1:0][`VLANE_XDATA_W-1:0] lane_alu_x_data_o,
    output logic [`VLANE_NUM-1:0][`VLANE_R_PORTS-1:0] lane_vrf_ren_o,
    output logic [`VLANE_NUM-1:0][`VLANE_R_PORTS-1:0][`VLANE_ADDR_W-1:0] lane_vrf_raddr_o
);

    import vlane_pkg::*;

    // Regs to interconnect
    logic issue_stb;
    logic [`VLANE_NUM-1:0] lane_en;
    logic [`VLANE_R_PORTS-1:0][`VLANE_RSEL_W-1:0] ralloc;
    logic [`VLANE_W_PORTS-1:0][`VLANE_ADDR_W-1:0] port_raddr;
    logic [`VLANE_W_PORTS-1:0] port_ren;
    logic [`VLANE_W_PORTS-2:0][`VLANE_BWEN_W-1:0] port_bwen;
    alu_op_e [`VLANE_W_PORTS-1:0] port_op;
    logic [`VLANE_W_PORTS-1:0][`VLANE_XDATA_W-1:0] port_xdata;
    logic [`VLANE_W_PORTS-2:0][`VLANE_ADDR_W-1:0] port_waddr_part;
    logic [`VLANE_NUM-1:0][`VLANE_ADDR_W-1:0] lane_waddr_cmp;
    logic [`VLANE_NUM-1:0][`VLANE_BWEN_W-1:0] lane_bwen_cmp;

    // Interconnect to gate, and counters back to regs
    logic cmd_valid;
    logic [`VLANE_NUM-1:0][`VLANE_CNT_W-1:0] lane_cnt;

    driver_apb_regs u_regs (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .apb_psel_i        (apb_psel_i),
        .apb_penable_i     (apb_penable_i),
        .apb_pwrite_i      (apb_pwrite_i),
        .apb_paddr_i       (apb_paddr_i),
        .apb_pwdata_i      (apb_pwdata_i),
        .apb_prdata_o      (apb_prdata_o),
        .apb_pready_o      (apb_pready_o),
        .apb_pslverr_o     (apb_pslverr_o),
        .lane_cnt_i        (lane_cnt),
        .issue_stb_o       (issue_stb),
        .lane_en_o         (lane_en),
        .ralloc_o          (ralloc),
        .port_raddr_o      (port_raddr),
        .port_ren_o        (port_ren),
        .port_bwen_o       (port_bwen),
        .port_op_o         (port_op),
        .port_xdata_o      (port_xdata),
        .port_waddr_part_o (port_waddr_part),
        .lane_waddr_cmp_o  (lane_waddr_cmp),
        .lane_bwen_cmp_o   (lane_bwen_cmp)
    );

    driver_vlane_interconnect u_icon (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .issue_stb_i       (issue_stb),
        .port_raddr_i      (port_raddr),
        .port_ren_i        (port_ren),
        .port_bwen_i       (port_bwen),
        .port_op_i         (port_op),
        .port_xdata_i      (port_xdata),
        .port_waddr_part_i (port_waddr_part),
        .lane_waddr_cmp_i  (lane_waddr_cmp),
        .lane_bwen_cmp_i   (lane_bwen_cmp),
        .ralloc_i          (ralloc),
        .cmd_valid_o       (cmd_valid),
        .vrf_waddr_o       (lane_vrf_waddr_o),
        .vrf_bwen_o        (lane_vrf_bwen_o),
        .alu_op_o          (lane_alu_op_o),
        .alu_x_data_o      (lane_alu_x_data_o),
        .vrf_ren_o         (lane_vrf_ren_o),
        .vrf_raddr_o       (lane_vrf_raddr_o)
    );

    lane_issue_gate u_gate (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .cmd_valid_i  (cmd_valid),
        .lane_en_i    (lane_en),
        .lane_valid_o (lane_valid_o),
        .lane_cnt_o   (lane_cnt)
    );

endmodule

/* hw/vlane_pkg.sv */
`include "vlane_settings.svh"

package vlane_pkg;

    // ALU opcodes, passed through to the lanes as is
    typedef enum logic [3:0] {
        ALU_ADD    = 4'h0,
        ALU_SUB    = 4'h1,
        ALU_AND    = 4'h2,
        ALU_OR     = 4'h3,
        ALU_XOR    = 4'h4,
        ALU_SLL    = 4'h5,
        ALU_SRL    = 4'h6,
        ALU_MUL    = 4'h7,
        ALU_REDSUM = 4'h8,
        ALU_NOP    = 4'hF
    } alu_op_e;

    // APB slave phase
    typedef enum logic [1:0] {
        APB_IDLE,
        APB_SETUP,
        APB_ACCESS
    } apb_phase_e;

    // Register map, indexed groups step by 4 per port or lane
    typedef enum logic [`VLANE_APB_AW-1:0] {
        REG_CTRL       = 8'h00,
        REG_RALLOC     = 8'h04,
        REG_PORT_CMD   = 8'h10,
        REG_PORT_XDATA = 8'h20,
        REG_LANE_WR    = 8'h30,
        REG_LANE_CNT   = 8'h40
    } reg_ofs_e;

endpackage

/* include/vlane_settings.svh */
`ifndef VLANE_SETTINGS_SVH
`define VLANE_SETTINGS_SVH

// Driver and lane geometry
`define VLANE_W_PORTS 4
`define VLANE_R_PORTS 8
`define VLANE_NUM 4

// VRF size, address width is log2 of the depth
`define VLANE_MEM_DEPTH 512
`define VLANE_ADDR_W 9

// Read port allocation entry, and the part of it that names a write port
`define VLANE_RSEL_W 3
`define VLANE_WSEL_W 2

// Command payload widths
`define VLANE_BWEN_W 4
`define VLANE_XDATA_W 32
`define VLANE_CNT_W 16

// APB
`define VLANE_APB_AW 8

`endif

/* verif/tb_vlane_driver.sv */
`timescale 1ns/1ps
`include "vlane_settings.svh"

module tb_vlane_driver;

    import vlane_pkg::*;

    localparam int NL = `VLANE_NUM;
    localparam int NW = `VLANE_W_PORTS;
    localparam int NR = `VLANE_R_PORTS;
    localparam int RW = `VLANE_RSEL_W;
    localparam int VALID_TIMEOUT = 20;
    localparam int READY_TIMEOUT = 16;

    logic clk_i;
    logic rst_i;
    logic apb_psel_i;
    logic apb_penable_i;
    logic apb_pwrite_i;
    logic [`VLANE_APB_AW-1:0] apb_paddr_i;
    logic [31:0] apb_pwdata_i;
    logic [31:0] apb_prdata_o;
    logic apb_pready_o;
    logic apb_pslverr_o;
    logic [NL-1:0] lane_valid_o;
    logic [NL-1:0][NW-1:0][`VLANE_ADDR_W-1:0] lane_vrf_waddr_o;
    logic [NL-1:0][NW-1:0][`VLANE_BWEN_W-1:0] lane_vrf_bwen_o;
    alu_op_e [NL-1:0][NW-1:0] lane_alu_op_o;
    logic [NL-1:0][NW-1:0][`VLANE_XDATA_W-1:0] lane_alu_x_data_o;
    logic [NL-1:0][NR-1:0] lane_vrf_ren_o;
    logic [NL-1:0][NR-1:0][`VLANE_ADDR_W-1:0] lane_vrf_raddr_o;

    // Register model, and the copy taken when a command is issued
    logic [26:0] cmd_m [NW];
    logic [31:0] xdata_m [NW];
    logic [12:0] lane_wr_m [NL];
    logic [RW-1:0] ralloc_m [NR];
    logic [NL-1:0] lane_en_m;
    int cnt_m [NL];
    logic [26:0] cmd_s [NW];
    logic [31:0] xdata_s [NW];
    logic [12:0] lane_wr_s [NL];
    logic [RW-1:0] ralloc_s [NR];

    int errors;
    int tests_passed;
    int tests_failed;

    vlane_driver_top UUT (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .apb_psel_i        (apb_psel_i),
        .apb_penable_i     (apb_penable_i),
        .apb_pwrite_i      (apb_pwrite_i),
        .apb_paddr_i       (apb_paddr_i),
        .apb_pwdata_i      (apb_pwdata_i),
        .apb_prdata_o      (apb_prdata_o),
        .apb_pready_o      (apb_pready_o),
        .apb_pslverr_o     (apb_pslverr_o),
        .lane_valid_o      (lane_valid_o),
        .lane_vrf_waddr_o  (lane_vrf_waddr_o),
        .lane_vrf_bwen_o   (lane_vrf_bwen_o),
        .lane_alu_op_o     (lane_alu_op_o),
        .lane_alu_x_data_o (lane_alu_x_data_o),
        .lane_vrf_ren_o    (lane_vrf_ren_o),
        .lane_vrf_raddr_o  (lane_vrf_raddr_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    ////////////////////////////////////////
    // Checking and reporting

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("[FAIL] %s expected 0x%h got 0x%h", name, exp, act);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int err_start);
        assert (errors == err_start) begin
            tests_passed++;
            $display("PASS %s", name);
        end else begin
            tests_failed++;
            $display("FAIL %s with %0d mismatches", name, errors - err_start);
        end
    endtask

    ////////////////////////////////////////
    // APB transfers start and end on a falling edge

    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            input logic exp_err, output logic [31:0] rdata);
        int wait_cnt;
        apb_psel_i    = 1'b1;
        apb_penable_i = 1'b0;
        apb_pwrite_i  = wr;
        apb_paddr_i   = addr;
        apb_pwdata_i  = wdata;
        @(negedge clk_i);
        apb_penable_i = 1'b1;
        #1;
        wait_cnt = 0;
        while (apb_pready_o !== 1'b1 && wait_cnt < READY_TIMEOUT) begin
            @(negedge clk_i);
            #1;
            wait_cnt++;
        end
        assert (apb_pready_o === 1'b1) else begin
            $display("APB transfer to 0x%h never saw pready", addr);
            errors++;
        end
        check_val($sformatf("apb_pslverr_o @0x%h", addr), 32'(exp_err), 32'(apb_pslverr_o));
        rdata = apb_prdata_o;
        @(negedge clk_i);
        apb_psel_i    = 1'b0;
        apb_penable_i = 1'b0;
        apb_pwrite_i  = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
        logic [31:0] unused_rd;
        apb_xfer(1'b1, addr, data, exp_err, unused_rd);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            input logic exp_err);
        apb_xfer(1'b0, addr, 32'h0, exp_err, data);
    endtask

    ////////////////////////////////////////
    // Register model

    function automatic void model_write(input logic [7:0] addr, input logic [31:0] data);
        int idx;
        idx = int'(addr[3:2]);
        case (addr[7:4])
            4'h0: begin
                if (addr == REG_CTRL) begin
                    lane_en_m = data[8 +: NL];
                end else if (addr == REG_RALLOC) begin
                    for (int k = 0; k < NR; k++) begin
                        ralloc_m[k] = data[RW*k +: RW];
                    end
                end
            end
            4'h1: cmd_m[idx] = data[26:0];
            4'h2: xdata_m[idx] = data;
            4'h3: lane_wr_m[idx] = data[12:0];
            default: ;
        endcase
    endfunction

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        apb_write(addr, data, 1'b0);
        model_write(addr, data);
    endtask

    function automatic logic [31:0] ralloc_word();
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < NR; k++) begin
            v[RW*k +: RW] = ralloc_m[k];
        end
        return v;
    endfunction

    function automatic logic [31:0] random_cmd();
        logic [31:0] v;
        int idx;
        v = $urandom();
        idx = $urandom_range(0, 9);
        v[17:14] = (idx == 9) ? ALU_NOP : alu_op_e'(idx);
        return v;
    endfunction

    // Only defined write port numbers go into the table
    function automatic logic [31:0] random_ralloc();
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < NR; k++) begin
            v[RW*k +: RW] = RW'($urandom_range(0, NW - 1));
        end
        return v;
    endfunction

    task automatic program_random_cmds();
        for (int p = 0; p < NW; p++) begin
            write_reg(8'(REG_PORT_CMD + 4 * p), random_cmd());
            write_reg(8'(REG_PORT_XDATA + 4 * p), $urandom());
        end
        for (int l = 0; l < NL; l++) begin
            write_reg(8'(REG_LANE_WR + 4 * l), $urandom() & 32'h1FFF);
        end
    endtask

    task automatic check_all_regs();
        logic [31:0] rd;
        apb_read(REG_CTRL, rd, 1'b0);
        check_val("apb_prdata_o CTRL", 32'(lane_en_m) << 8, rd);
        apb_read(REG_RALLOC, rd, 1'b0);
        check_val("apb_prdata_o RALLOC", ralloc_word(), rd);
        for (int p = 0; p < NW; p++) begin
            apb_read(8'(REG_PORT_CMD + 4 * p), rd, 1'b0);
            check_val($sformatf("apb_prdata_o PORT_CMD%0d", p), 32'(cmd_m[p]), rd);
            apb_read(8'(REG_PORT_XDATA + 4 * p), rd, 1'b0);
            check_val($sformatf("apb_prdata_o PORT_XDATA%0d", p), xdata_m[p], rd);
        end
        for (int l = 0; l < NL; l++) begin
            apb_read(8'(REG_LANE_WR + 4 * l), rd, 1'b0);
            check_val($sformatf("apb_prdata_o LANE_WR%0d", l), 32'(lane_wr_m[l]), rd);
            apb_read(8'(REG_LANE_CNT + 4 * l), rd, 1'b0);
            check_val($sformatf("apb_prdata_o LANE_CNT%0d", l), 32'(cnt_m[l]), rd);
        end
    endtask

    ////////////////////////////////////////
    // Issue and lane output checks

    // Cycles counted from the falling edge after the access cycle
    task automatic wait_lane_valid(output int cycles);
        cycles = 0;
        while (cycles < VALID_TIMEOUT) begin
            @(negedge clk_i);
            cycles++;
            if (|lane_valid_o) begin
                return;
            end
        end
        $display("Timeout waiting %0d cycles for lane_valid_o", VALID_TIMEOUT);
        errors++;
        cycles = -1;
    endtask

    task automatic check_lane_outputs();
        int wp;
        for (int l = 0; l < NL; l++) begin
            for (int p = 0; p < NW; p++) begin
                // Port 0 is the complete port and the rest share the partial fields
                check_val($sformatf("lane_vrf_waddr_o[%0d][%0d]", l, p),
                          (p == 0) ? 32'(lane_wr_s[l][8:0]) : 32'(cmd_s[p][26:18]),
                          32'(lane_vrf_waddr_o[l][p]));
                check_val($sformatf("lane_vrf_bwen_o[%0d][%0d]", l, p),
                          (p == 0) ? 32'(lane_wr_s[l][12:9]) : 32'(cmd_s[p][13:10]),
                          32'(lane_vrf_bwen_o[l][p]));
                check_val($sformatf("lane_alu_op_o[%0d][%0d]", l, p),
                          32'(cmd_s[p][17:14]), 32'(lane_alu_op_o[l][p]));
                check_val($sformatf("lane_alu_x_data_o[%0d][%0d]", l, p),
                          xdata_s[p], lane_alu_x_data_o[l][p]);
            end
            for (int k = 0; k < NR; k++) begin
                wp = int'(ralloc_s[k]) % NW;
                check_val($sformatf("lane_vrf_ren_o[%0d][%0d]", l, k),
                          32'(cmd_s[wp][9]), 32'(lane_vrf_ren_o[l][k]));
                check_val($sformatf("lane_vrf_raddr_o[%0d][%0d]", l, k),
                          32'(cmd_s[wp][8:0]), 32'(lane_vrf_raddr_o[l][k]));
            end
        end
    endtask

    task automatic issue_and_check();
        int lat;
        cmd_s     = cmd_m;
        xdata_s   = xdata_m;
        lane_wr_s = lane_wr_m;
        ralloc_s  = ralloc_m;
        for (int l = 0; l < NL; l++) begin
            if (lane_en_m[l] && cnt_m[l] < 32'hFFFF) begin
                cnt_m[l]++;
            end
        end
        apb_write(REG_CTRL, (32'(lane_en_m) << 8) | 32'h1, 1'b0);
        wait_lane_valid(lat);
        if (lat >= 0) begin
            check_val("lane_valid_o delay", 32'd1, 32'(lat));
            check_val("lane_valid_o", 32'(lane_en_m), 32'(lane_valid_o));
            check_lane_outputs();
            @(negedge clk_i);
            check_val("lane_valid_o after one cycle", 32'h0, 32'(lane_valid_o));
        end
    endtask

    ////////////////////////////////////////
    // Tests

    task automatic test_reset_readback();
        int e0;
        e0 = errors;
        check_val("lane_valid_o", 32'h0, 32'(lane_valid_o));
        check_all_regs();
        for (int p = 0; p < NW; p++) begin
            write_reg(8'(REG_PORT_CMD + 4 * p), $urandom());
            write_reg(8'(REG_PORT_XDATA + 4 * p), $urandom());
        end
        for (int l = 0; l < NL; l++) begin
            write_reg(8'(REG_LANE_WR + 4 * l), $urandom() & 32'h1FFF);
        end
        check_all_regs();
        end_test("reset_readback", e0);
    endtask

    task automatic test_write_split();
        int e0;
        e0 = errors;
        program_random_cmds();
        issue_and_check();
        end_test("write_port_split", e0);
    endtask

    task automatic test_read_routing();
        int e0;
        e0 = errors;
        program_random_cmds();
        write_reg(REG_RALLOC, random_ralloc());
        issue_and_check();
        end_test("read_port_routing", e0);
    endtask

    task automatic test_inflight();
        int e0;
        e0 = errors;
        program_random_cmds();
        write_reg(REG_RALLOC, random_ralloc());
        issue_and_check();
        // New table and commands that are not yet issued
        write_reg(REG_RALLOC, random_ralloc());
        for (int p = 0; p < NW; p++) begin
            write_reg(8'(REG_PORT_CMD + 4 * p), random_cmd());
        end
        check_val("lane_valid_o", 32'h0, 32'(lane_valid_o));
        check_lane_outputs();
        issue_and_check();
        end_test("inflight_isolation", e0);
    endtask

    task automatic test_mask_counters();
        int e0;
        int n;
        int base [NL];
        logic [NL-1:0] mask;
        logic [31:0] rd;
        e0 = errors;
        base = cnt_m;
        mask = NL'($urandom_range(1, (1 << NL) - 2));
        write_reg(REG_CTRL, 32'(mask) << 8);
        n = $urandom_range(3, 8);
        repeat (n) begin
            program_random_cmds();
            issue_and_check();
        end
        for (int l = 0; l < NL; l++) begin
            apb_read(8'(REG_LANE_CNT + 4 * l), rd, 1'b0);
            check_val($sformatf("apb_prdata_o LANE_CNT%0d", l),
                      32'(base[l] + (mask[l] ? n : 0)), rd);
        end
        write_reg(REG_CTRL, 32'({NL{1'b1}}) << 8);
        end_test("lane_mask_counters", e0);
    endtask

    task automatic test_apb_errors();
        int e0;
        logic [7:0] bad;
        logic [31:0] rd;
        e0 = errors;
        bad = 8'h50 + 8'($urandom_range(0, 43) << 2);
        apb_read(bad, rd, 1'b1);
        apb_read(8'h08, rd, 1'b1);
        // Issue bit set on offsets that must not issue
        apb_write(8'h0C, 32'h1, 1'b1);
        apb_write(bad, $urandom() | 32'h1, 1'b1);
        for (int l = 0; l < NL; l++) begin
            apb_write(8'(REG_LANE_CNT + 4 * l), 32'hFFFF_FFFF, 1'b1);
        end
        repeat (6) begin
            @(negedge clk_i);
            check_val("lane_valid_o", 32'h0, 32'(lane_valid_o));
        end
        check_all_regs();
        end_test("apb_errors", e0);
    endtask

    ////////////////////////////////////////
    // Main sequence

    initial begin
        void'($urandom(26));
        errors        = 0;
        tests_passed  = 0;
        tests_failed  = 0;
        rst_i         = 1'b0;
        apb_psel_i    = 1'b0;
        apb_penable_i = 1'b0;
        apb_pwrite_i  = 1'b0;
        apb_paddr_i   = '0;
        apb_pwdata_i  = '0;
        lane_en_m     = '1;
        for (int p = 0; p < NW; p++) begin
            cmd_m[p]   = '0;
            xdata_m[p] = '0;
        end
        for (int l = 0; l < NL; l++) begin
            lane_wr_m[l] = '0;
            cnt_m[l]     = 0;
        end
        for (int k = 0; k < NR; k++) begin
            ralloc_m[k] = RW'(k % NW);
        end

        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b1;
        @(negedge clk_i);

        test_reset_readback();
        test_write_split();
        test_read_routing();
        test_inflight();
        test_mask_counters();
        test_apb_errors();

        $display("Summary: pass count %0d, fail count %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
